// ==== build.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_control.sv
design/reg_file.sv
design/forward.sv
design/exec_stage.sv
design/mem_stage.sv
design/core_top.sv
testbench/tb_clock.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: core_pipe

sources:
  - files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/pipe_control.sv
      - design/reg_file.sv
      - design/forward.sv
      - design/exec_stage.sv
      - design/mem_stage.sv
      - design/core_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/core_tb.sv

// ==== testbench/core_tb.sv ====
`timescale 1ns/10ps
module core_tb;
	localparam int DMEM_WORDS = 64;
	localparam int CLK_PERIOD = 20;
	localparam int RAND_COUNT = 400;
	localparam int NUM_INSTR = RAND_COUNT + 40;
	localparam int MAX_CYCLES = NUM_INSTR * 5 * 3 + 100;  // issue, stall and gap, three times over

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic        instr_ready;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	logic [31:0] ref_regs [32];  // sequential reference model
	logic [31:0] ref_dmem [DMEM_WORDS];
	logic [4:0]  q_addr [$];
	logic [31:0] q_data [$];
	int          q_due [$];  // rising edge where wb_valid is expected
	int          edge_cnt;
	int          stall_edge;
	int          last_x2_edge;
	logic        last_is_lw;
	logic [4:0]  last_rt;
	logic        exp_ready;
	logic        exp_due;
	logic [4:0]  exp_addr;
	logic [31:0] exp_data;

	tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk);

	core_top #(.DMEM_WORDS(DMEM_WORDS)) UUT (
		.clk, .reset, .instr_valid, .instr, .instr_ready, .wb_valid, .wb_addr, .wb_data
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] alu_word(input logic [2:0] fn, input logic [4:0] rt,
		input logic [4:0] ra, input logic [4:0] rb);
		return {isa_pkg::OP_ALU, rt, ra, rb, 8'h00, fn};
	endfunction

	function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [15:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic logic [4:0] random_reg();
		return 5'($urandom % 8);  // few registers, many dependences
	endfunction

	task automatic model_accept(input logic [31:0] w);
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [31:0] imm;
		logic [31:0] res;
		logic        wr;
		logic        stalled;
		int          acc;
		int          addr;
		rt = w[25:21];
		ra = w[20:16];
		rb = w[15:11];
		imm = {{16{w[15]}}, w[15:0]};
		acc = edge_cnt + 1;  // transfer at the coming rising edge
		// a load entering execute as this word enters decode holds decode one cycle
		stalled = last_is_lw && last_x2_edge == acc
			&& (rt == last_rt || ra == last_rt || rb == last_rt);
		if (stalled)
			stall_edge = acc + 1;
		last_x2_edge = acc + 1 + int'(stalled);
		last_is_lw = (w[31:26] == isa_pkg::OP_LW);
		last_rt = rt;
		wr = 1'b1;
		res = '0;
		addr = int'((ref_regs[ra] + imm) % DMEM_WORDS);
		case (w[31:26])
			isa_pkg::OP_ALU: begin
				case (w[2:0])
					isa_pkg::FN_SUB: res = ref_regs[ra] - ref_regs[rb];
					isa_pkg::FN_AND: res = ref_regs[ra] & ref_regs[rb];
					isa_pkg::FN_OR:  res = ref_regs[ra] | ref_regs[rb];
					isa_pkg::FN_XOR: res = ref_regs[ra] ^ ref_regs[rb];
					isa_pkg::FN_SLT: res = ($signed(ref_regs[ra]) < $signed(ref_regs[rb])) ? 1 : 0;
					default:         res = ref_regs[ra] + ref_regs[rb];
				endcase
			end
			isa_pkg::OP_ADDI: res = ref_regs[ra] + imm;
			isa_pkg::OP_LI:   res = imm;
			isa_pkg::OP_LW:   res = ref_dmem[addr];
			isa_pkg::OP_SW: begin
				ref_dmem[addr] = ref_regs[rt];
				wr = 1'b0;
			end
			default: wr = 1'b0;
		endcase
		if (wr) begin
			ref_regs[rt] = res;
			q_addr.push_back(rt);
			q_data.push_back(res);
			q_due.push_back(acc + 4 + int'(stalled));
		end
	endtask

	task automatic issue(input logic [31:0] w);
		instr_valid = 1'b1;
		instr = w;
		while (!instr_ready)
			@(negedge clk);
		model_accept(w);
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		instr_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	// expected port values for the coming rising edge
	always @(negedge clk) begin
		exp_ready = (stall_edge != edge_cnt + 1);
		if (q_due.size() != 0 && q_due[0] == edge_cnt + 1) begin
			exp_due = 1'b1;
			exp_addr = q_addr.pop_front();
			exp_data = q_data.pop_front();
			void'(q_due.pop_front());
		end else begin
			exp_due = 1'b0;
		end
	end

	a_ready: assert property (@(posedge clk) disable iff (reset) instr_ready == exp_ready)
		else abort_run($sformatf("error at time %0t: instr_ready is %b, expected %b",
			$time, $sampled(instr_ready), $sampled(exp_ready)));
	a_retire: assert property (@(posedge clk) disable iff (reset) wb_valid == exp_due)
		else abort_run($sformatf("error at time %0t: wb_valid is %b, expected %b",
			$time, $sampled(wb_valid), $sampled(exp_due)));
	a_retire_addr: assert property (@(posedge clk) disable iff (reset)
		exp_due |-> wb_addr == exp_addr)
		else abort_run($sformatf("error at time %0t: wb_addr is %0d, expected %0d",
			$time, $sampled(wb_addr), $sampled(exp_addr)));
	a_retire_data: assert property (@(posedge clk) disable iff (reset)
		exp_due |-> wb_data == exp_data)
		else abort_run($sformatf("error at time %0t: wb_data is %h, expected %h",
			$time, $sampled(wb_data), $sampled(exp_data)));

	initial begin
		#(MAX_CYCLES * CLK_PERIOD);
		abort_run("timeout: the pipeline stopped accepting or retiring instructions");
	end

	initial begin
		logic [31:0] w;
		int          kind;
		void'($urandom(32'h12150904));
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		edge_cnt = 0;
		stall_edge = -1;
		last_x2_edge = -1;
		last_is_lw = 1'b0;
		last_rt = '0;
		exp_ready = 1'b1;
		exp_due = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		foreach (ref_regs[i])
			ref_regs[i] = '0;
		foreach (ref_dmem[i])
			ref_dmem[i] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		issue(imm_word(isa_pkg::OP_LI, 5'd1, 5'd0, 16'h8001));  // negative immediate
		issue(alu_word(isa_pkg::FN_ADD, 5'd2, 5'd1, 5'd1));
		idle(6);
		issue(imm_word(isa_pkg::OP_LI, 5'd3, 5'd0, 16'd5));
		issue(imm_word(isa_pkg::OP_LI, 5'd4, 5'd0, 16'hfff9));
		issue(alu_word(isa_pkg::FN_ADD, 5'd5, 5'd3, 5'd4));
		issue(alu_word(isa_pkg::FN_SUB, 5'd6, 5'd5, 5'd3));  // r3 from write-back
		issue(imm_word(isa_pkg::OP_ADDI, 5'd7, 5'd6, 16'd100));
		issue(alu_word(isa_pkg::FN_XOR, 5'd8, 5'd7, 5'd5));
		issue(alu_word(isa_pkg::FN_SLT, 5'd9, 5'd4, 5'd8));
		issue(alu_word(isa_pkg::FN_AND, 5'd10, 5'd9, 5'd6));
		issue(alu_word(isa_pkg::FN_OR, 5'd11, 5'd7, 5'd10));
		issue(imm_word(isa_pkg::OP_ADDI, 5'd11, 5'd11, 16'hffff));
		issue(imm_word(isa_pkg::OP_SW, 5'd8, 5'd0, 16'd12));
		issue(imm_word(isa_pkg::OP_LW, 5'd12, 5'd0, 16'd12));
		issue(alu_word(isa_pkg::FN_ADD, 5'd13, 5'd12, 5'd3));  // ra match
		issue(imm_word(isa_pkg::OP_LW, 5'd14, 5'd0, 16'd12));
		issue(alu_word(isa_pkg::FN_SUB, 5'd15, 5'd3, 5'd14));  // rb match
		issue(imm_word(isa_pkg::OP_LW, 5'd16, 5'd0, 16'd12));
		issue(imm_word(isa_pkg::OP_LI, 5'd16, 5'd0, 16'd7));  // rt match only
		issue(imm_word(isa_pkg::OP_LW, 5'd17, 5'd0, 16'd12));
		issue(imm_word(isa_pkg::OP_ADDI, 5'd18, 5'd3, 16'd1));  // no match
		issue(imm_word(isa_pkg::OP_ADDI, 5'd19, 5'd7, 16'd3));
		issue(imm_word(isa_pkg::OP_SW, 5'd19, 5'd0, 16'd20));
		issue(imm_word(isa_pkg::OP_LW, 5'd20, 5'd0, 16'(20 + DMEM_WORDS)));
		issue(imm_word(isa_pkg::OP_SW, 5'd20, 5'd0, 16'hffc2));  // wraps to word 2
		issue(imm_word(isa_pkg::OP_LW, 5'd21, 5'd0, 16'(2 + DMEM_WORDS)));
		for (int n = 0; n < RAND_COUNT; n++) begin
			kind = $urandom % 8;
			case (kind)
				0: w = imm_word(isa_pkg::OP_NOP, random_reg(), random_reg(), 16'($urandom));
				4: w = imm_word(isa_pkg::OP_ADDI, random_reg(), random_reg(), 16'($urandom));
				5: w = imm_word(isa_pkg::OP_LI, random_reg(), random_reg(), 16'($urandom));
				6: w = imm_word(isa_pkg::OP_LW, random_reg(), random_reg(), 16'($urandom));
				7: w = imm_word(isa_pkg::OP_SW, random_reg(), random_reg(), 16'($urandom));
				default: w = alu_word(3'($urandom % 6), random_reg(), random_reg(), random_reg());
			endcase
			issue(w);
			if ($urandom % 6 == 0)
				idle(1 + $urandom % 3);
		end
		idle(1);
		while (q_due.size() != 0)
			@(negedge clk);
		idle(4);  // nothing may retire once the model is drained
		$display("ALL CHECKS PASSED");
		$finish;
	end
endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps
module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end
endmodule

// ==== design/core_top.sv ====
`timescale 1ns/10ps
module core_top #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            instr_valid,
	input  logic [31:0]                     instr,
	output logic                            instr_ready,
	output logic                            wb_valid,
	output logic [pipe_pkg::REG_ADDR_W-1:0] wb_addr,
	output logic [31:0]                     wb_data
);
	logic                            stall;
	logic                            do_hazard;
	logic [pipe_pkg::REG_ADDR_W-1:0] reg_ra_addr;
	logic [pipe_pkg::REG_ADDR_W-1:0] reg_rb_addr;
	logic [pipe_pkg::REG_ADDR_W-1:0] reg_rt_addr;
	logic [31:0]                     dec_imm;
	logic [31:0]                     reg_ra_data;
	logic [31:0]                     reg_rb_data;
	logic [31:0]                     reg_rt_data;
	logic [31:0]                     f_reg_ra_data;
	logic [31:0]                     f_reg_rb_data;
	logic [31:0]                     f_reg_rt_data;
	logic                            x2_do_reg_write;
	logic                            x2_do_dm_read;
	pipe_pkg::wrreg_sel_e            x2_select_write_reg;
	logic [pipe_pkg::REG_ADDR_W-1:0] x2_write_reg_addr;
	pipe_pkg::alu_op_e               x2_alu_op;
	logic                            x2_use_imm;
	logic [31:0]                     alu_result;
	logic [31:0]                     x2_imm_extend;
	logic [31:0]                     x2_store_data;
	logic                            x3_do_reg_write;
	logic                            x3_do_dm_write;
	pipe_pkg::wrreg_sel_e            x3_select_write_reg;
	logic [pipe_pkg::REG_ADDR_W-1:0] x3_write_reg_addr;
	logic [31:0]                     write_reg_data;
	logic                            x4_do_reg_write;
	logic [pipe_pkg::REG_ADDR_W-1:0] x4_write_reg_addr;
	logic [31:0]                     x4_write_reg_data;

	pipe_control u_ctrl (
		.clk, .reset, .instr_valid, .instr, .instr_ready, .do_hazard, .stall,
		.reg_ra_addr, .reg_rb_addr, .reg_rt_addr, .dec_imm,
		.x2_do_reg_write, .x2_do_dm_read,
		.x2_do_dm_write(),  // store flag is only needed from x3 on
		.x2_select_write_reg, .x2_write_reg_addr, .x2_alu_op, .x2_use_imm,
		.x3_do_reg_write, .x3_do_dm_write, .x3_select_write_reg, .x3_write_reg_addr,
		.x4_do_reg_write, .x4_write_reg_addr
	);

	reg_file u_rf (
		.clk, .reset,
		.ra_addr(reg_ra_addr), .rb_addr(reg_rb_addr), .rt_addr(reg_rt_addr),
		.ra_data(reg_ra_data), .rb_data(reg_rb_data), .rt_data(reg_rt_data),
		.we(x4_do_reg_write), .wr_addr(x4_write_reg_addr), .wr_data(x4_write_reg_data)
	);

	forward u_fwd (
		.reg_ra_addr, .reg_rb_addr, .reg_rt_addr, .reg_ra_data, .reg_rb_data, .reg_rt_data,
		.x2_do_dm_read, .x2_do_reg_write, .x2_select_write_reg, .x2_write_reg_addr,
		.alu_result, .x2_imm_extend,
		.x3_do_reg_write, .x3_write_reg_addr, .write_reg_data,
		.x4_do_reg_write, .x4_write_reg_addr, .x4_write_reg_data,
		.f_reg_ra_data, .f_reg_rb_data, .f_reg_rt_data, .do_hazard
	);

	exec_stage u_ex (
		.clk, .reset, .stall, .x2_alu_op, .x2_use_imm,
		.f_reg_ra_data, .f_reg_rb_data, .f_reg_rt_data, .dec_imm,
		.alu_result, .x2_imm_extend, .x2_store_data
	);

	mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
		.clk, .reset, .alu_result, .x2_imm_extend, .x2_store_data,
		.x3_do_dm_write, .x3_select_write_reg, .write_reg_data, .x4_write_reg_data
	);

	// retire port is the register file write
	assign wb_valid = x4_do_reg_write;
	assign wb_addr = x4_write_reg_addr;
	assign wb_data = x4_write_reg_data;

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/10ps
module mem_stage #(
	parameter int DMEM_WORDS = 64
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [31:0]          alu_result,
	input  logic [31:0]          x2_imm_extend,
	input  logic [31:0]          x2_store_data,
	input  logic                 x3_do_dm_write,
	input  pipe_pkg::wrreg_sel_e x3_select_write_reg,
	output logic [31:0]          write_reg_data,
	output logic [31:0]          x4_write_reg_data
);
	localparam int DM_ADDR_W = $clog2(DMEM_WORDS);

	logic [31:0]          dmem [DMEM_WORDS];
	logic [31:0]          x3_alu_result;
	logic [31:0]          x3_imm_extend;
	logic [31:0]          x3_store_data;
	logic [31:0]          dm_read_data;
	logic [DM_ADDR_W-1:0] dm_addr;

	always_ff @(posedge clk) begin
		x3_alu_result <= alu_result;
		x3_imm_extend <= x2_imm_extend;
		x3_store_data <= x2_store_data;
	end

	assign dm_addr = x3_alu_result[DM_ADDR_W-1:0];  // word address wraps at the RAM depth
	assign dm_read_data = dmem[dm_addr];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (x3_do_dm_write) begin
			dmem[dm_addr] <= x3_store_data;
		end
	end

	always_comb begin
		case (x3_select_write_reg)
			pipe_pkg::WRREG_IMMDATA: write_reg_data = x3_imm_extend;
			pipe_pkg::WRREG_MEMDATA: write_reg_data = dm_read_data;
			default:                 write_reg_data = x3_alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		x4_write_reg_data <= write_reg_data;
	end

	// decode never marks one instruction as both load and store
	a_store_not_load: assert property (@(posedge clk) disable iff (reset)
		x3_do_dm_write |-> x3_select_write_reg != pipe_pkg::WRREG_MEMDATA)
		else $error("store issued with memory data selected for write-back");

endmodule

// ==== design/exec_stage.sv ====
`timescale 1ns/10ps
module exec_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  pipe_pkg::alu_op_e x2_alu_op,
	input  logic              x2_use_imm,
	input  logic [31:0]       f_reg_ra_data,
	input  logic [31:0]       f_reg_rb_data,
	input  logic [31:0]       f_reg_rt_data,
	input  logic [31:0]       dec_imm,
	output logic [31:0]       alu_result,
	output logic [31:0]       x2_imm_extend,
	output logic [31:0]       x2_store_data
);
	logic [31:0] x2_ra_data;
	logic [31:0] x2_rb_data;
	logic [31:0] alu_b;

	always_ff @(posedge clk) begin
		if (reset || stall) begin  // bubble operands are don't care
			x2_ra_data <= '0;
			x2_rb_data <= '0;
			x2_imm_extend <= '0;
			x2_store_data <= '0;
		end else begin
			x2_ra_data <= f_reg_ra_data;
			x2_rb_data <= f_reg_rb_data;
			x2_imm_extend <= dec_imm;
			x2_store_data <= f_reg_rt_data;  // sw data comes from rt
		end
	end

	assign alu_b = x2_use_imm ? x2_imm_extend : x2_rb_data;

	always_comb begin
		case (x2_alu_op)
			pipe_pkg::ALU_SUB: alu_result = x2_ra_data - alu_b;
			pipe_pkg::ALU_AND: alu_result = x2_ra_data & alu_b;
			pipe_pkg::ALU_OR:  alu_result = x2_ra_data | alu_b;
			pipe_pkg::ALU_XOR: alu_result = x2_ra_data ^ alu_b;
			pipe_pkg::ALU_SLT: alu_result = {31'b0, $signed(x2_ra_data) < $signed(alu_b)};
			default:           alu_result = x2_ra_data + alu_b;
		endcase
	end

endmodule

// ==== design/forward.sv ====
`timescale 1ns/10ps
module forward (
	input  logic [pipe_pkg::REG_ADDR_W-1:0] reg_ra_addr,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] reg_rb_addr,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] reg_rt_addr,
	input  logic [31:0]                     reg_ra_data,
	input  logic [31:0]                     reg_rb_data,
	input  logic [31:0]                     reg_rt_data,
	input  logic                            x2_do_dm_read,
	input  logic                            x2_do_reg_write,
	input  pipe_pkg::wrreg_sel_e            x2_select_write_reg,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] x2_write_reg_addr,
	input  logic [31:0]                     alu_result,
	input  logic [31:0]                     x2_imm_extend,
	input  logic                            x3_do_reg_write,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] x3_write_reg_addr,
	input  logic [31:0]                     write_reg_data,
	input  logic                            x4_do_reg_write,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] x4_write_reg_addr,
	input  logic [31:0]                     x4_write_reg_data,
	output logic [31:0]                     f_reg_ra_data,
	output logic [31:0]                     f_reg_rb_data,
	output logic [31:0]                     f_reg_rt_data,
	output logic                            do_hazard
);
	logic        x2_fwd;
	logic [31:0] x2_fwd_data;

	// load data is not there yet in x2, the hazard covers it
	assign x2_fwd = x2_do_reg_write && !x2_do_dm_read
		&& (x2_select_write_reg == pipe_pkg::WRREG_IMMDATA
		|| x2_select_write_reg == pipe_pkg::WRREG_ALURESULT);
	assign x2_fwd_data = (x2_select_write_reg == pipe_pkg::WRREG_IMMDATA) ?
		x2_imm_extend : alu_result;

	// youngest write wins, so x2 is checked last
	function automatic logic [31:0] pick(input logic [pipe_pkg::REG_ADDR_W-1:0] addr,
		input logic [31:0] rf_data);
		logic [31:0] d;
		d = rf_data;
		if (x4_do_reg_write && addr == x4_write_reg_addr)
			d = x4_write_reg_data;
		if (x3_do_reg_write && addr == x3_write_reg_addr)
			d = write_reg_data;
		if (x2_fwd && addr == x2_write_reg_addr)
			d = x2_fwd_data;
		return d;
	endfunction

	always_comb begin
		f_reg_ra_data = pick(reg_ra_addr, reg_ra_data);
		f_reg_rb_data = pick(reg_rb_addr, reg_rb_data);
		f_reg_rt_data = pick(reg_rt_addr, reg_rt_data);
	end

	assign do_hazard = x2_do_dm_read
		&& (reg_rt_addr == x2_write_reg_addr
		|| reg_ra_addr == x2_write_reg_addr
		|| reg_rb_addr == x2_write_reg_addr);

	// a load in x2 is always a register write as well, decode sets both
	always_comb begin
		a_hazard_load: assert final (!do_hazard || (x2_do_dm_read && x2_do_reg_write))
			else $error("load-use hazard without a load in execute");
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps
module reg_file (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] ra_addr,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] rb_addr,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] rt_addr,
	output logic [31:0]                     ra_data,
	output logic [31:0]                     rb_data,
	output logic [31:0]                     rt_data,
	input  logic                            we,
	input  logic [pipe_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [31:0]                     wr_data
);
	localparam int NUM_REGS = 1 << pipe_pkg::REG_ADDR_W;

	logic [31:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// no write bypass, a same-cycle write shows up in forward instead
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

// ==== design/pipe_control.sv ====
`timescale 1ns/10ps
module pipe_control (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              instr_valid,
	input  isa_pkg::inst_word_u               instr,
	output logic                              instr_ready,
	input  logic                              do_hazard,
	output logic                              stall,
	output logic [pipe_pkg::REG_ADDR_W-1:0]   reg_ra_addr,
	output logic [pipe_pkg::REG_ADDR_W-1:0]   reg_rb_addr,
	output logic [pipe_pkg::REG_ADDR_W-1:0]   reg_rt_addr,
	output logic [31:0]                       dec_imm,
	output logic                              x2_do_reg_write,
	output logic                              x2_do_dm_read,
	output logic                              x2_do_dm_write,
	output pipe_pkg::wrreg_sel_e              x2_select_write_reg,
	output logic [pipe_pkg::REG_ADDR_W-1:0]   x2_write_reg_addr,
	output pipe_pkg::alu_op_e                 x2_alu_op,
	output logic                              x2_use_imm,
	output logic                              x3_do_reg_write,
	output logic                              x3_do_dm_write,
	output pipe_pkg::wrreg_sel_e              x3_select_write_reg,
	output logic [pipe_pkg::REG_ADDR_W-1:0]   x3_write_reg_addr,
	output logic                              x4_do_reg_write,
	output logic [pipe_pkg::REG_ADDR_W-1:0]   x4_write_reg_addr
);
	logic                 dec_valid;
	isa_pkg::inst_word_u  dec_instr;
	logic                 issue;
	logic                 d_reg_write;
	logic                 d_dm_read;
	logic                 d_dm_write;
	logic                 d_use_imm;
	pipe_pkg::wrreg_sel_e d_sel;
	pipe_pkg::alu_op_e    d_alu_op;

	assign stall = do_hazard & dec_valid;
	assign instr_ready = !stall;
	assign issue = dec_valid & !stall;  // decode moves into x2 this cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
			dec_instr <= '0;
		end else if (!stall) begin
			dec_valid <= instr_valid;
			if (instr_valid)
				dec_instr <= instr;
		end
	end

	assign reg_ra_addr = dec_instr.r.ra;
	assign reg_rb_addr = dec_instr.r.rb;
	assign reg_rt_addr = dec_instr.r.rt;
	assign dec_imm = {{16{dec_instr.i.imm[15]}}, dec_instr.i.imm};

	always_comb begin
		d_reg_write = 1'b0;
		d_dm_read = 1'b0;
		d_dm_write = 1'b0;
		d_use_imm = 1'b0;
		d_sel = pipe_pkg::WRREG_ALURESULT;
		d_alu_op = pipe_pkg::ALU_ADD;
		case (dec_instr.r.opcode)
			isa_pkg::OP_ALU: begin
				d_reg_write = 1'b1;
				case (dec_instr.r.funct)
					isa_pkg::FN_SUB: d_alu_op = pipe_pkg::ALU_SUB;
					isa_pkg::FN_AND: d_alu_op = pipe_pkg::ALU_AND;
					isa_pkg::FN_OR:  d_alu_op = pipe_pkg::ALU_OR;
					isa_pkg::FN_XOR: d_alu_op = pipe_pkg::ALU_XOR;
					isa_pkg::FN_SLT: d_alu_op = pipe_pkg::ALU_SLT;
					default:         d_alu_op = pipe_pkg::ALU_ADD;
				endcase
			end
			isa_pkg::OP_ADDI: begin
				d_reg_write = 1'b1;
				d_use_imm = 1'b1;
			end
			isa_pkg::OP_LI: begin
				d_reg_write = 1'b1;
				d_sel = pipe_pkg::WRREG_IMMDATA;
			end
			isa_pkg::OP_LW: begin
				d_reg_write = 1'b1;
				d_dm_read = 1'b1;
				d_use_imm = 1'b1;
				d_sel = pipe_pkg::WRREG_MEMDATA;
			end
			isa_pkg::OP_SW: begin
				d_dm_write = 1'b1;
				d_use_imm = 1'b1;
			end
			default: d_reg_write = 1'b0;  // nop and unknown opcodes
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			x2_do_reg_write <= 1'b0;
			x2_do_dm_read <= 1'b0;
			x2_do_dm_write <= 1'b0;
			x2_select_write_reg <= pipe_pkg::WRREG_ALURESULT;
			x2_write_reg_addr <= '0;
			x2_alu_op <= pipe_pkg::ALU_ADD;
			x2_use_imm <= 1'b0;
			x3_do_reg_write <= 1'b0;
			x3_do_dm_write <= 1'b0;
			x3_select_write_reg <= pipe_pkg::WRREG_ALURESULT;
			x3_write_reg_addr <= '0;
			x4_do_reg_write <= 1'b0;
			x4_write_reg_addr <= '0;
		end else begin
			x2_do_reg_write <= d_reg_write & issue;  // bubble on stall
			x2_do_dm_read <= d_dm_read & issue;
			x2_do_dm_write <= d_dm_write & issue;
			x2_select_write_reg <= d_sel;
			x2_write_reg_addr <= reg_rt_addr;
			x2_alu_op <= d_alu_op;
			x2_use_imm <= d_use_imm;
			x3_do_reg_write <= x2_do_reg_write;
			x3_do_dm_write <= x2_do_dm_write;
			x3_select_write_reg <= x2_select_write_reg;
			x3_write_reg_addr <= x2_write_reg_addr;
			x4_do_reg_write <= x3_do_reg_write;
			x4_write_reg_addr <= x3_write_reg_addr;
		end
	end

	// the bubble behind a stall can never be a load
	a_single_stall: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
		else $error("decode stalled two cycles in a row");

endmodule

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

	localparam int REG_ADDR_W = 5;

	// where the register write data comes from
	typedef enum logic [1:0] {
		WRREG_ALURESULT = 2'd0,
		WRREG_IMMDATA   = 2'd1,
		WRREG_MEMDATA   = 2'd2
	} wrreg_sel_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,  // also addi, lw and sw address
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_e;

endpackage

// ==== design/isa_pkg.sv ====
package isa_pkg;

	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ALU  = 6'd1,  // register-register, funct picks the operation
		OP_ADDI = 6'd2,
		OP_LI   = 6'd3,  // rt <= sign-extended imm
		OP_LW   = 6'd4,
		OP_SW   = 6'd5
	} opcode_e;

	typedef enum logic [2:0] {
		FN_ADD = 3'd0,
		FN_SUB = 3'd1,
		FN_AND = 3'd2,
		FN_OR  = 3'd3,
		FN_XOR = 3'd4,
		FN_SLT = 3'd5   // signed compare
	} funct_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [7:0] unused;
		funct_e     funct;
	} inst_r_t;

	// rb of the R view sits on imm[15:11]
	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [15:0] imm;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_word_u;

endpackage
